// ==== src/nabp_pkg.sv ====
package nabp_pkg;

    // image geometry
    localparam int k_image_size = 8;
    localparam int k_no_of_pixels = k_image_size * k_image_size;
    localparam int k_no_of_partitions = 2;
    localparam int k_rows_per_partition = k_image_size / k_no_of_partitions;
    localparam int k_pixels_per_partition = k_no_of_pixels / k_no_of_partitions;

    // projection geometry, angles 0/45/90/135 only
    localparam int k_no_of_angles = 4;
    localparam int k_no_of_bins = 2 * k_image_size - 1;

    // field widths
    localparam int k_angle_length = 2;
    localparam int k_bin_length = 4;
    localparam int k_coord_length = 3;
    localparam int k_pixel_index_length = 5;
    localparam int k_sinogram_address_length = 6;
    localparam int k_image_address_length = 6;

    // data widths
    // raw sample unsigned, filtered and accumulated values signed
    localparam int k_data_length = 8;
    localparam int k_filtered_data_length = 10;
    localparam int k_cache_data_length = 16;

    // detector bin hit by pixel (x, y) at a given angle
    function automatic logic [k_bin_length-1:0] bin_of(
        input logic [k_angle_length-1:0] angle,
        input logic [k_coord_length-1:0] x,
        input logic [k_coord_length-1:0] y
    );
        logic [k_bin_length-1:0] xe;
        logic [k_bin_length-1:0] ye;
        xe = k_bin_length'(x);
        ye = k_bin_length'(y);
        case (angle)
            2'd0: bin_of = xe;
            2'd1: bin_of = xe + ye;
            2'd2: bin_of = ye;
            // offset keeps x - y non-negative
            default: bin_of = xe + k_bin_length'(k_image_size - 1) - ye;
        endcase
    endfunction

endpackage

// ==== src/nabp_sinogram_addresser.sv ====
`timescale 1ns/1ns

module nabp_sinogram_addresser
    import nabp_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 sg_kick,
    input  logic                                 fill_ready,
    input  logic                                 busy,
    output logic [k_sinogram_address_length-1:0] sg_addr,
    output logic                                 wr_valid,
    output logic [k_bin_length-1:0]              wr_bin,
    output logic [k_angle_length-1:0]            wr_angle,
    output logic                                 wr_last
);

    // run_active spans issue and scan, drops once readout owns the engine
    logic run_active;
    logic issuing;
    logic [k_angle_length-1:0] angle;
    logic [k_bin_length-1:0] bin;
    logic issue;
    logic row_end;

    // a row only starts when a bank is free, then runs without stalls
    assign issue = issuing && (bin != '0 || fill_ready);
    assign row_end = bin == k_bin_length'(k_no_of_bins - 1);

    // address = angle * 15 + bin
    assign sg_addr = k_sinogram_address_length'(angle) *
                     k_sinogram_address_length'(k_no_of_bins) +
                     k_sinogram_address_length'(bin);

    always_ff @(posedge clk) begin
        if (reset) begin
            run_active <= 1'b0;
            issuing <= 1'b0;
            angle <= '0;
            bin <= '0;
        end else if (sg_kick && !run_active && !busy) begin
            run_active <= 1'b1;
            issuing <= 1'b1;
            angle <= '0;
            bin <= '0;
        end else begin
            if (busy) begin
                run_active <= 1'b0;
            end
            if (issue) begin
                if (row_end) begin
                    bin <= '0;
                    angle <= angle + 1'b1;
                    // last row of the sinogram
                    if (angle == k_angle_length'(k_no_of_angles - 1)) begin
                        issuing <= 1'b0;
                    end
                end else begin
                    bin <= bin + 1'b1;
                end
            end
        end
    end

    // tag stage, lines up with the one-cycle RAM read
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_valid <= 1'b0;
            wr_last <= 1'b0;
        end else begin
            wr_valid <= issue;
            wr_last <= issue && row_end;
        end
    end

    always_ff @(posedge clk) begin
        wr_bin <= bin;
        wr_angle <= angle;
    end

    a_bin_range: assert property (@(posedge clk) disable iff (reset)
        wr_valid |-> wr_bin < k_bin_length'(k_no_of_bins));

endmodule

// ==== src/nabp_filter.sv ====
`timescale 1ns/1ns

module nabp_filter
    import nabp_pkg::*;
(
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [k_data_length-1:0]                 val_in,
    input  logic                                     in_valid,
    input  logic [k_bin_length-1:0]                  in_bin,
    output logic signed [k_filtered_data_length-1:0] val_out
);

    // previous sample of the current row
    logic [k_data_length-1:0] history;
    logic [k_data_length-1:0] prev;

    // no left neighbour at bin 0
    assign prev = (in_bin == '0) ? '0 : history;

    // 2*s[n] - s[n-1]
    assign val_out = $signed(k_filtered_data_length'({val_in, 1'b0})) -
                     $signed(k_filtered_data_length'(prev));

    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
        end else if (in_valid) begin
            history <= val_in;
        end
    end

endmodule

// ==== src/nabp_filtered_swap.sv ====
`timescale 1ns/1ns

module nabp_filtered_swap
    import nabp_pkg::*;
(
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     wr_valid,
    input  logic [k_bin_length-1:0]                  wr_bin,
    input  logic [k_angle_length-1:0]                wr_angle,
    input  logic                                     wr_last,
    input  logic signed [k_filtered_data_length-1:0] wr_val,
    input  logic                                     pe_scan_done,
    input  logic [k_bin_length-1:0]                  pr0_bin,
    input  logic [k_bin_length-1:0]                  pr1_bin,
    output logic                                     fill_ready,
    output logic                                     pe_kick,
    output logic [k_angle_length-1:0]                pe_angle,
    output logic signed [k_filtered_data_length-1:0] pr0_val,
    output logic signed [k_filtered_data_length-1:0] pr1_val,
    output logic                                     sg_done
);

    // two filtered rows, one filling while the other is scanned
    logic signed [k_filtered_data_length-1:0] bank [2][k_no_of_bins];
    logic [k_angle_length-1:0] bank_angle [2];
    logic [1:0] full;
    logic fill_ptr;
    logic proc_ptr;
    // high from pe_kick until the scan ends
    logic scanning;
    logic launch;
    logic release_bank;

    // no new row while the previous one is still arriving
    assign fill_ready = !wr_valid && !full[fill_ptr];
    assign launch = !scanning && full[proc_ptr];
    assign release_bank = scanning && pe_scan_done;

    // taps read straight from the active bank
    assign pr0_val = bank[proc_ptr][pr0_bin];
    assign pr1_val = bank[proc_ptr][pr1_bin];

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            bank[fill_ptr][wr_bin] <= wr_val;
        end
        if (wr_valid && wr_last) begin
            bank_angle[fill_ptr] <= wr_angle;
        end
        if (launch) begin
            pe_angle <= bank_angle[proc_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= '0;
            fill_ptr <= 1'b0;
            proc_ptr <= 1'b0;
            scanning <= 1'b0;
            pe_kick <= 1'b0;
            sg_done <= 1'b0;
        end else begin
            pe_kick <= 1'b0;
            sg_done <= 1'b0;
            // row complete, hand bank over and move fill side on
            if (wr_valid && wr_last) begin
                full[fill_ptr] <= 1'b1;
                fill_ptr <= !fill_ptr;
            end
            if (release_bank) begin
                full[proc_ptr] <= 1'b0;
                proc_ptr <= !proc_ptr;
                scanning <= 1'b0;
                // last angle scanned, whole sinogram done
                sg_done <= bank_angle[proc_ptr] == k_angle_length'(k_no_of_angles - 1);
            end else if (launch) begin
                pe_kick <= 1'b1;
                scanning <= 1'b1;
            end
        end
    end

    a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
        wr_valid |-> !full[fill_ptr]);

endmodule

// ==== src/nabp_processing_element.sv ====
`timescale 1ns/1ns

module nabp_processing_element
    import nabp_pkg::*;
#(
    parameter int pe_id = 0
)
(
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     sg_kick,
    input  logic                                     pe_kick,
    input  logic [k_angle_length-1:0]                pe_angle,
    input  logic signed [k_filtered_data_length-1:0] pr_val,
    input  logic                                     domino_kick,
    input  logic                                     ir_advance,
    input  logic signed [k_cache_data_length-1:0]    pe_in_val,
    output logic [k_bin_length-1:0]                  pr_bin,
    output logic                                     pe_scan_done,
    output logic                                     domino_done,
    output logic signed [k_cache_data_length-1:0]    pe_out_val
);

    // one accumulator per pixel of this partition
    logic signed [k_cache_data_length-1:0] acc [k_pixels_per_partition];
    // ready for a fresh run, dropped once accumulators are cleared
    logic armed;
    logic kick_accept;
    logic scanning;
    logic owning;
    logic [k_pixel_index_length-1:0] scan_idx;
    logic [k_pixel_index_length-1:0] rd_idx;
    logic [k_angle_length-1:0] angle;
    logic [k_coord_length-1:0] px;
    logic [k_coord_length-1:0] py;
    logic signed [k_cache_data_length-1:0] tap_ext;

    assign kick_accept = sg_kick && armed;

    // low bits pick the column, high bits the row within the partition
    assign px = scan_idx[k_coord_length-1:0];
    assign py = k_coord_length'(pe_id * k_rows_per_partition) +
                k_coord_length'(scan_idx[k_pixel_index_length-1:k_coord_length]);
    assign pr_bin = bin_of(angle, px, py);

    // sign extend tap to accumulator width
    assign tap_ext = {{(k_cache_data_length - k_filtered_data_length){pr_val[k_filtered_data_length-1]}},
                      pr_val};

    assign pe_scan_done = scanning &&
                          scan_idx == k_pixel_index_length'(k_pixels_per_partition - 1);

    // last pixel of the partition accepted, pass the chain on
    assign domino_done = owning && ir_advance &&
                         rd_idx == k_pixel_index_length'(k_pixels_per_partition - 1);

    // own pixel while holding the chain, upstream value otherwise
    assign pe_out_val = owning ? acc[rd_idx] : pe_in_val;

    always_ff @(posedge clk) begin
        if (kick_accept) begin
            for (int i = 0; i < k_pixels_per_partition; i++) begin
                acc[i] <= '0;
            end
        end else if (scanning) begin
            acc[scan_idx] <= acc[scan_idx] + tap_ext;
        end
    end

    // angle latched with the kick, held through the scan
    always_ff @(posedge clk) begin
        if (pe_kick) begin
            angle <= pe_angle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            armed <= 1'b1;
            scanning <= 1'b0;
            owning <= 1'b0;
            scan_idx <= '0;
            rd_idx <= '0;
        end else begin
            if (kick_accept) begin
                armed <= 1'b0;
            end else if (domino_done) begin
                armed <= 1'b1;
            end
            // scan
            if (pe_kick) begin
                scanning <= 1'b1;
                scan_idx <= '0;
            end else if (scanning) begin
                scan_idx <= scan_idx + 1'b1;
                if (pe_scan_done) begin
                    scanning <= 1'b0;
                end
            end
            // readout
            if (domino_kick) begin
                owning <= 1'b1;
                rd_idx <= '0;
            end else if (owning && ir_advance) begin
                rd_idx <= rd_idx + 1'b1;
                if (domino_done) begin
                    owning <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== src/nabp_image_addresser.sv ====
`timescale 1ns/1ns

module nabp_image_addresser
    import nabp_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              sg_done,
    input  logic                              ir_enable,
    output logic                              ir_valid,
    output logic                              ir_advance,
    output logic [k_image_address_length-1:0] ir_addr,
    output logic                              ir_done,
    output logic                              busy
);

    // readout in progress
    logic active;

    assign ir_valid = active;
    assign busy = active;
    // one pixel moves per accepted cycle
    assign ir_advance = active && ir_enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            ir_addr <= '0;
            ir_done <= 1'b0;
        end else begin
            ir_done <= 1'b0;
            if (!active) begin
                if (sg_done) begin
                    active <= 1'b1;
                    ir_addr <= '0;
                end
            end else if (ir_enable) begin
                ir_addr <= ir_addr + 1'b1;
                // final pixel taken
                if (ir_addr == k_image_address_length'(k_no_of_pixels - 1)) begin
                    active <= 1'b0;
                    ir_done <= 1'b1;
                end
            end
        end
    end

    a_addr_hold: assert property (@(posedge clk) disable iff (reset)
        ir_valid && !ir_enable |=> $stable(ir_addr));

endmodule

// ==== src/nabp.sv ====
`timescale 1ns/1ns

module nabp
    import nabp_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  sg_kick,
    input  logic [k_data_length-1:0]              sg_val,
    input  logic                                  ir_enable,
    output logic                                  sg_done,
    output logic [k_sinogram_address_length-1:0]  sg_addr,
    output logic                                  ir_valid,
    output logic                                  ir_done,
    output logic [k_image_address_length-1:0]     ir_addr,
    output logic signed [k_cache_data_length-1:0] ir_val
);

    // addresser tag
    logic wr_valid;
    logic [k_bin_length-1:0] wr_bin;
    logic [k_angle_length-1:0] wr_angle;
    logic wr_last;
    logic signed [k_filtered_data_length-1:0] fl_val;
    logic fill_ready;
    logic busy;
    // no kick reaches the elements while readout runs
    logic pe_sg_kick;
    // swap control to processing elements
    logic pe_kick;
    logic [k_angle_length-1:0] pe_angle;
    logic pe_scan_done;
    logic [k_bin_length-1:0] pr0_bin;
    logic [k_bin_length-1:0] pr1_bin;
    logic signed [k_filtered_data_length-1:0] pr0_val;
    logic signed [k_filtered_data_length-1:0] pr1_val;
    // domino chain
    logic ir_advance;
    logic pe0_domino_done;
    logic signed [k_cache_data_length-1:0] pe0_out_val;

    assign pe_sg_kick = sg_kick && !busy;

    nabp_sinogram_addresser sinogram_addresser (
        .clk(clk),
        .reset(reset),
        .sg_kick(sg_kick),
        .fill_ready(fill_ready),
        .busy(busy),
        .sg_addr(sg_addr),
        .wr_valid(wr_valid),
        .wr_bin(wr_bin),
        .wr_angle(wr_angle),
        .wr_last(wr_last)
    );

    nabp_filter filter (
        .clk(clk),
        .reset(reset),
        .val_in(sg_val),
        .in_valid(wr_valid),
        .in_bin(wr_bin),
        .val_out(fl_val)
    );

    nabp_filtered_swap filtered_swap (
        .clk(clk),
        .reset(reset),
        .wr_valid(wr_valid),
        .wr_bin(wr_bin),
        .wr_angle(wr_angle),
        .wr_last(wr_last),
        .wr_val(fl_val),
        .pe_scan_done(pe_scan_done),
        .pr0_bin(pr0_bin),
        .pr1_bin(pr1_bin),
        .fill_ready(fill_ready),
        .pe_kick(pe_kick),
        .pe_angle(pe_angle),
        .pr0_val(pr0_val),
        .pr1_val(pr1_val),
        .sg_done(sg_done)
    );

    // partition 0, head of the chain, kicked by sg_done
    nabp_processing_element #(.pe_id(0)) processing_element_0 (
        .clk(clk),
        .reset(reset),
        .sg_kick(pe_sg_kick),
        .pe_kick(pe_kick),
        .pe_angle(pe_angle),
        .pr_val(pr0_val),
        .domino_kick(sg_done),
        .ir_advance(ir_advance),
        .pe_in_val('0),
        .pr_bin(pr0_bin),
        .pe_scan_done(pe_scan_done),
        .domino_done(pe0_domino_done),
        .pe_out_val(pe0_out_val)
    );

    // partition 1, tail drives the image RAM
    nabp_processing_element #(.pe_id(1)) processing_element_1 (
        .clk(clk),
        .reset(reset),
        .sg_kick(pe_sg_kick),
        .pe_kick(pe_kick),
        .pe_angle(pe_angle),
        .pr_val(pr1_val),
        .domino_kick(pe0_domino_done),
        .ir_advance(ir_advance),
        .pe_in_val(pe0_out_val),
        .pr_bin(pr1_bin),
        .pe_scan_done(),
        .domino_done(),
        .pe_out_val(ir_val)
    );

    nabp_image_addresser image_addresser (
        .clk(clk),
        .reset(reset),
        .sg_done(sg_done),
        .ir_enable(ir_enable),
        .ir_valid(ir_valid),
        .ir_advance(ir_advance),
        .ir_addr(ir_addr),
        .ir_done(ir_done),
        .busy(busy)
    );

endmodule

// ==== bench/nabp_tb.sv ====
`timescale 1ns/1ns

module nabp_tb
    import nabp_pkg::*;
();

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic sg_kick = 1'b0;
    logic [k_data_length-1:0] sg_val = '0;
    logic ir_enable = 1'b0;
    logic sg_done;
    logic [k_sinogram_address_length-1:0] sg_addr;
    logic ir_valid;
    logic ir_done;
    logic [k_image_address_length-1:0] ir_addr;
    logic signed [k_cache_data_length-1:0] ir_val;

    // sinogram RAM, 4 rows of 15 bins
    logic [k_data_length-1:0] sino_mem [k_no_of_angles * k_no_of_bins];
    logic [k_sinogram_address_length-1:0] ram_addr;
    // address behind the sample now on sg_val
    logic [k_sinogram_address_length-1:0] data_addr;

    logic [31:0] lfsr_state = 32'hbb74_f094;
    logic backpressure = 1'b0;
    // marks the cycle of the accepted kick, counters restart there
    logic run_start = 1'b0;
    string test_name = "reset";

    // per-run counters, owned by the checker
    int issue_count = 0;
    int sg_done_count = 0;
    int transfer_count = 0;
    int done_count = 0;

    nabp DUT (
        .clk(clk),
        .reset(reset),
        .sg_kick(sg_kick),
        .sg_val(sg_val),
        .ir_enable(ir_enable),
        .sg_done(sg_done),
        .sg_addr(sg_addr),
        .ir_valid(ir_valid),
        .ir_done(ir_done),
        .ir_addr(ir_addr),
        .ir_val(ir_val)
    );

    always #50 clk = ~clk;

    // address taken mid cycle, data back one cycle later
    always @(negedge clk) begin
        if (int'(ram_addr) < k_no_of_angles * k_no_of_bins) begin
            sg_val <= sino_mem[ram_addr];
        end else begin
            sg_val <= '0;
        end
        data_addr <= ram_addr;
        ram_addr <= sg_addr;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit
    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    task automatic fill_sinogram();
        logic [7:0] byte_val;
        for (int i = 0; i < k_no_of_angles * k_no_of_bins; i++) begin
            take_bits(8, byte_val);
            sino_mem[i] = byte_val;
        end
    endtask

    // expected pixel: sum over angles of the filtered tap hit by (x, y)
    function automatic logic signed [k_cache_data_length-1:0] ref_pixel(input int idx);
        int x;
        int y;
        int b;
        int f;
        int sum;
        x = idx % k_image_size;
        y = idx / k_image_size;
        sum = 0;
        for (int a = 0; a < k_no_of_angles; a++) begin
            case (a)
                0: b = x;
                1: b = x + y;
                2: b = y;
                default: b = x - y + 7;
            endcase
            // 2*s[b] - s[b-1], nothing left of bin 0
            f = 2 * int'(sino_mem[a * k_no_of_bins + b]);
            if (b > 0) begin
                f = f - int'(sino_mem[a * k_no_of_bins + b - 1]);
            end
            sum = sum + f;
        end
        return k_cache_data_length'(sum);
    endfunction

    task automatic abort_sim();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic show_mismatch(input string what, input int expected, input int actual);
        $display("MISMATCH %s %s expected %0d actual %0d", test_name, what, expected, actual);
        abort_sim();
    endtask

    task automatic explain_failure(input string text);
        $display("ERROR in %s: %s", test_name, text);
        abort_sim();
    endtask

    // next falling edge, ir_enable random only under back-pressure
    task automatic tick();
        logic [7:0] b;
        @(negedge clk);
        if (backpressure) begin
            take_bits(1, b);
            ir_enable = b[0];
        end else begin
            ir_enable = 1'b1;
        end
    endtask

    task automatic wait_reads(input int count, input int limit);
        int cycles;
        cycles = 0;
        do begin
            tick();
            cycles++;
        end while (issue_count < count && cycles < limit);
        assert (issue_count >= count) else explain_failure("timeout waiting for sinogram reads");
    endtask

    task automatic wait_sg_done(input int limit);
        int cycles;
        cycles = 0;
        do begin
            tick();
            cycles++;
        end while (!sg_done && cycles < limit);
        assert (sg_done) else explain_failure("timeout waiting for sg_done");
    endtask

    task automatic wait_ir_done(input int limit);
        int cycles;
        cycles = 0;
        do begin
            tick();
            cycles++;
        end while (!ir_done && cycles < limit);
        assert (ir_done) else explain_failure("timeout waiting for ir_done");
    endtask

    task automatic run_image(input string name, input logic random_enable,
                             input logic extra_kick);
        test_name = name;
        backpressure = 1'b0;
        fill_sinogram();
        sg_kick = 1'b1;
        run_start = 1'b1;
        backpressure = random_enable;
        tick();
        sg_kick = 1'b0;
        run_start = 1'b0;
        if (extra_kick) begin
            // second kick once two rows are in, first row then mid scan
            wait_reads(2 * k_no_of_bins, 200);
            sg_kick = 1'b1;
            tick();
            sg_kick = 1'b0;
        end
        wait_sg_done(1000);
        wait_ir_done(3000);
        backpressure = 1'b0;
        // room for a stray second ir_done
        repeat (4) tick();
        assert (issue_count == k_no_of_angles * k_no_of_bins)
            else show_mismatch("sinogram reads", k_no_of_angles * k_no_of_bins, issue_count);
        assert (sg_done_count == 1) else show_mismatch("sg_done pulses", 1, sg_done_count);
        assert (transfer_count == k_no_of_pixels)
            else show_mismatch("pixel transfers", k_no_of_pixels, transfer_count);
        assert (done_count == 1) else show_mismatch("ir_done pulses", 1, done_count);
    endtask

    // sampled on the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (run_start) begin
            issue_count <= 0;
            sg_done_count <= 0;
            transfer_count <= 0;
            done_count <= 0;
        end else if (!reset) begin
            // reads arrive in order 0..59, i.e. angle*15 + bin
            if (DUT.wr_valid) begin
                assert (int'(data_addr) == issue_count)
                    else show_mismatch("sinogram address", issue_count, int'(data_addr));
                issue_count <= issue_count + 1;
            end
            if (sg_done) begin
                sg_done_count <= sg_done_count + 1;
            end
            if (ir_valid && ir_enable) begin
                assert (int'(ir_addr) == transfer_count)
                    else show_mismatch("image address", transfer_count, int'(ir_addr));
                assert (ir_val == ref_pixel(int'(ir_addr)))
                    else show_mismatch($sformatf("pixel %0d", ir_addr),
                                       int'(ref_pixel(int'(ir_addr))), int'(ir_val));
                transfer_count <= transfer_count + 1;
            end
            if (ir_done) begin
                assert (transfer_count == k_no_of_pixels)
                    else explain_failure("ir_done came before all pixels were taken");
                done_count <= done_count + 1;
            end
        end
    end

    initial begin
        repeat (5) @(negedge clk);
        reset = 1'b0;
        run_image("baseline", 1'b0, 1'b0);
        // fresh data also shows the accumulators were cleared
        run_image("backpressure", 1'b1, 1'b0);
        run_image("kick_during_run", 1'b0, 1'b1);
        $display("Test passed");
        $finish;
    end

endmodule

// ==== project.f ====
src/nabp_pkg.sv
src/nabp_sinogram_addresser.sv
src/nabp_filter.sv
src/nabp_filtered_swap.sv
src/nabp_processing_element.sv
src/nabp_image_addresser.sv
src/nabp.sv
bench/nabp_tb.sv

// ==== Makefile ====
TOOL := verilator
FLAGS := --binary --timing
TOP := nabp_tb
FILELIST := project.f

SOURCES := $(shell cat $(FILELIST))
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
